//--- verilog.f
+incdir+tests
hw/mipsPkg.sv
hw/alu.sv
hw/instrDecoder.sv
hw/registerFile.sv
hw/pcUnit.sv
hw/mipsCore.sv
tests/mipsCoreTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mipsCoreTb
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

word_t mRegs [32];        // Model register file
word_t mMem  [DataWords]; // Model data memory
word_t mPc;               // Model program counter
logic  expWe;             // Expected store strobe this cycle
word_t expAddr;           // Expected store address
word_t expData;           // Expected store data

function automatic int randBelow(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

function automatic word_t fillWord(input int a);
    return word_t'(a) * 32'h9E3779B1 + 32'h0BADF00D;  // Differs in every address bit
endfunction

// One random instruction for word idx, targets never point backwards
function automatic word_t genInstr(input int idx);
    logic [4:0]  rs, rt, rd;
    logic [15:0] imm;
    logic [5:0]  fn;
    int          span;
    word_t       w;
    rs   = 5'(randBelow(8));     // Small register set so values get reused
    rt   = 5'(randBelow(8));
    rd   = 5'(randBelow(8));
    imm  = 16'($random(seed));
    fn   = 6'($random(seed));
    span = (ProgLen - 1 - idx < 8) ? ProgLen - 1 - idx : 8;  // Stay inside the program
    case (randBelow(15))
        0:       w = {opRtype, rs, rt, rd, 5'd0, fnAdd};
        1:       w = {opRtype, rs, rt, rd, 5'd0, fnSub};
        2:       w = {opRtype, rs, rt, rd, 5'd0, fnAnd};
        3:       w = {opRtype, rs, rt, rd, 5'd0, fnOr};
        4:       w = {opRtype, rs, rt, rd, 5'd0, fnSlt};
        5:       w = {opRtype, rs, rt, rd, 5'd0, fn};   // Mostly undefined funct
        6, 7:    w = {opAddi, rs, rt, imm};              // Negative immediates too
        8:       w = {opLw, 5'd0, rt, 16'(randBelow(DataWords) * 4)};
        9, 10:   w = {opSw, 5'd0, rt, 16'(randBelow(DataWords) * 4)};
        11:      w = {opBeq, rs, rt, 16'(randBelow(span))};
        12:      w = {opBne, rs, rt, 16'(randBelow(span))};
        13:      w = {opJ, 26'(idx + 1 + randBelow(span))};
        default: w = {6'(16 + randBelow(8)), rs, rt, imm};  // Opcodes 16..23 undefined
    endcase
    return w;
endfunction

// Executes the instruction at mPc and sets the expected port values
task automatic stepModel();
    word_t      w, a, b, simm, ea, result, nextPc;
    logic [5:0] fn;
    logic [4:0] dest;
    logic       wr;
    w       = progMem[mPc[ProgAddrBits+1:2]];
    fn      = w[5:0];
    a       = mRegs[w[25:21]];
    b       = mRegs[w[20:16]];
    simm    = {{16{w[15]}}, w[15:0]};
    ea      = a + simm;              // lw/sw address, also addi sum
    result  = ea;
    nextPc  = mPc + 32'd4;
    dest    = w[20:16];              // I-type writes rt
    wr      = 1'b0;
    expWe   = 1'b0;
    expAddr = ea;
    expData = b;
    case (w[31:26])
        opRtype: begin
            dest = w[15:11];
            wr   = 1'b1;
            case (fn)
                fnAdd:   result = a + b;
                fnSub:   result = a - b;
                fnAnd:   result = a & b;
                fnOr:    result = a | b;
                fnSlt:   result = {31'd0, $signed(a) < $signed(b)};
                default: wr = 1'b0;  // Undefined funct changes nothing
            endcase
        end
        opAddi:  wr = 1'b1;
        opLw: begin
            wr     = 1'b1;
            result = mMem[ea[DataAddrBits+1:2]];
        end
        opSw: begin
            expWe = 1'b1;
            mMem[ea[DataAddrBits+1:2]] = b;
        end
        opBeq:   if (a == b) nextPc = nextPc + {simm[29:0], 2'b00};
        opBne:   if (a != b) nextPc = nextPc + {simm[29:0], 2'b00};
        opJ:     nextPc = {nextPc[31:28], w[25:0], 2'b00};
        default: ;                   // Undefined opcode just advances
    endcase
    if (wr && dest != 5'd0) mRegs[dest] = result;  // r0 stays zero
    mPc = nextPc;
endtask

`endif

//--- tests/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;
    import mipsPkg::*;

    localparam int    ClkPeriod    = 4;
    localparam int    ResetCycles  = 3;
    localparam int    ProgLen      = 200;   // Program words
    localparam int    DataWords    = 64;    // Data memory words
    localparam int    ProgAddrBits = $clog2(ProgLen);
    localparam int    DataAddrBits = $clog2(DataWords);
    localparam int    TimeoutNs    = (ProgLen * 2 + ResetCycles) * ClkPeriod;
    localparam word_t LastPc       = word_t'((ProgLen - 1) * 4);  // Jump-to-self

    logic   Clk;
    logic   rstN;
    word_t  instrAddr, instr, memAddr, memWriteData, memReadData;
    logic   memWriteEn;
    word_t  progMem [ProgLen];   // Instruction memory
    word_t  dataMem [DataWords]; // Data memory seen by the DUT
    integer seed;
    int     errors;
    int     checks;
    int     idleCycles;          // Cycles spent on the final jump

    `include "isaModel.svh"

    mipsCore #(
        .ResetPc ('0)
    ) dut0 (
        .Clk          (Clk),
        .rstN         (rstN),
        .instrAddr    (instrAddr),
        .instr        (instr),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWriteEn   (memWriteEn),
        .memReadData  (memReadData)
    );

    always #(ClkPeriod / 2) Clk = ~Clk;

    assign instr       = rstN ? progMem[instrAddr[ProgAddrBits+1:2]] : '0;  // Zero in reset
    assign memReadData = dataMem[memAddr[DataAddrBits+1:2]];                 // Async read

    always @(posedge Clk) begin
        if (!rstN) begin
            for (int a = 0; a < DataWords; a++) begin
                dataMem[a] <= fillWord(a);   // Same contents as the model
            end
        end else if (memWriteEn) begin
            dataMem[memAddr[DataAddrBits+1:2]] <= memWriteData;
        end
    end

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected)
            else begin
                errors++;
                $display("FAILED at %0d ns: %s expected %h, got %h",
                         $time, name, expected, actual);
            end
    endtask

    initial begin
        #(TimeoutNs);
        $display("Timeout: run did not finish within %0d ns", TimeoutNs);
        $display("Checks: %0d  errors: %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        Clk        = 1'b0;
        rstN       = 1'b0;
        seed       = 57918;
        errors     = 0;
        checks     = 0;
        idleCycles = 0;
        for (int i = 0; i < ProgLen - 1; i++) begin
            progMem[i] = genInstr(i);
        end
        progMem[ProgLen-1] = {opJ, 26'(ProgLen - 1)};  // Program ends spinning here
        mRegs = '{default: '0};
        mPc   = '0;
        for (int a = 0; a < DataWords; a++) begin
            mMem[a] = fillWord(a);
        end
        repeat (ResetCycles - 1) @(posedge Clk);
        @(negedge Clk);
        checkWord("instrAddr", '0, instrAddr);              // PC at reset address
        checkWord("memWriteEn", '0, word_t'(memWriteEn));   // No store in reset
        @(posedge Clk);
        #1 rstN = 1'b1;
        while (idleCycles < 2) begin
            @(negedge Clk);                                 // Outputs settled
            if (mPc == LastPc) idleCycles++;
            checkWord("instrAddr", mPc, instrAddr);
            stepModel();
            checkWord("memWriteEn", word_t'(expWe), word_t'(memWriteEn));
            if (expWe) begin
                checkWord("memAddr", expAddr, memAddr);
                checkWord("memWriteData", expData, memWriteData);
            end
        end
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- hw/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
    parameter mipsPkg::word_t ResetPc = '0      // Fetch address after reset
) (
    input  logic           Clk,
    input  logic           rstN,                // Sync reset, active low
    output mipsPkg::word_t instrAddr,           // Fetch address
    input  mipsPkg::word_t instr,               // Fetched word, combinational
    output mipsPkg::word_t memAddr,             // Load/store address
    output mipsPkg::word_t memWriteData,        // Store data
    output logic           memWriteEn,          // Store strobe
    input  mipsPkg::word_t memReadData          // Load data, combinational
);
    import mipsPkg::*;

    regAddr_t                  rsAddr;          // Source register numbers
    regAddr_t                  rtAddr;
    regAddr_t                  regWriteAddr;    // Destination register
    word_t                     imm;             // Sign-extended immediate
    logic [JumpIndexWidth-1:0] jumpIndex;       // Jump target field
    logic                      regWriteEn;
    logic                      memToReg;        // Write back load data
    logic                      aluSrcImm;       // Immediate as ALU operand B
    logic                      branchEq;
    logic                      branchNe;
    logic                      jump;
    aluOp_e                    aluOp;
    word_t                     rsData;          // Register read ports
    word_t                     rtData;
    word_t                     aluResult;
    logic                      aluZero;         // Branch compare result
    word_t                     pc;

    instrDecoder decoder0 (
        .instr        (instr),
        .rsAddr       (rsAddr),
        .rtAddr       (rtAddr),
        .regWriteAddr (regWriteAddr),
        .imm          (imm),
        .jumpIndex    (jumpIndex),
        .regWriteEn   (regWriteEn),
        .memWriteEn   (memWriteEn),               // Straight to the data port
        .memToReg     (memToReg),
        .aluSrcImm    (aluSrcImm),
        .branchEq     (branchEq),
        .branchNe     (branchNe),
        .jump         (jump),
        .aluOp        (aluOp)
    );

    registerFile regFile0 (
        .Clk          (Clk),
        .rstN         (rstN),
        .rsAddr       (rsAddr),
        .rtAddr       (rtAddr),
        .regWriteAddr (regWriteAddr),
        .regWriteEn   (regWriteEn),
        .memToReg     (memToReg),
        .aluResult    (aluResult),
        .memReadData  (memReadData),
        .rsData       (rsData),
        .rtData       (rtData)
    );

    alu alu0 (
        .rsData    (rsData),
        .rtData    (rtData),
        .imm       (imm),
        .aluSrcImm (aluSrcImm),
        .aluOp     (aluOp),
        .aluResult (aluResult),
        .aluZero   (aluZero)
    );

    pcUnit #(
        .ResetPc (ResetPc)
    ) pcUnit0 (
        .Clk       (Clk),
        .rstN      (rstN),
        .branchEq  (branchEq),
        .branchNe  (branchNe),
        .jump      (jump),
        .aluZero   (aluZero),
        .imm       (imm),
        .jumpIndex (jumpIndex),
        .pc        (pc)
    );

    assign instrAddr    = pc;         // Fetch from current PC
    assign memAddr      = aluResult;  // Base plus offset for lw/sw
    assign memWriteData = rtData;     // sw stores rt

endmodule

//--- hw/pcUnit.sv
`timescale 1ns/1ps

module pcUnit #(
    parameter mipsPkg::word_t ResetPc = '0       // Address loaded in reset
) (
    input  logic                               Clk,
    input  logic                               rstN,
    input  logic                               branchEq,   // beq in decode
    input  logic                               branchNe,   // bne in decode
    input  logic                               jump,
    input  logic                               aluZero,    // rs equals rt
    input  mipsPkg::word_t                     imm,        // Branch offset in words
    input  logic [mipsPkg::JumpIndexWidth-1:0] jumpIndex,  // Jump word index
    output mipsPkg::word_t                     pc
);
    import mipsPkg::*;

    localparam int SegBits = WordWidth - JumpIndexWidth - 2;  // Kept upper PC bits

    word_t pcPlus4;       // Sequential address
    word_t branchTarget;  // pcPlus4 plus word offset
    word_t jumpTarget;    // Same segment, new index
    word_t nextPc;
    logic  branchTaken;

    assign pcPlus4      = pc + WordWidth'(4);
    assign branchTarget = pcPlus4 + {imm[WordWidth-3:0], 2'b00};
    assign jumpTarget   = {pcPlus4[WordWidth-1 -: SegBits], jumpIndex, 2'b00};
    assign branchTaken  = (branchEq && aluZero) || (branchNe && !aluZero);

    always_comb begin
        if (jump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;   // Also for unknown opcodes
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc <= ResetPc;
        end else begin
            pc <= nextPc;
        end
    end

    // Fetch address stays on a word boundary once out of reset
    assertPcAligned: assert property (@(posedge Clk) disable iff (!rstN)
        pc[1:0] == 2'b00)
        else $error("pc misaligned at %h", pc);

endmodule

//--- hw/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic              Clk,
    input  logic              rstN,
    input  mipsPkg::regAddr_t rsAddr,
    input  mipsPkg::regAddr_t rtAddr,
    input  mipsPkg::regAddr_t regWriteAddr,
    input  logic              regWriteEn,
    input  logic              memToReg,      // Load result instead of ALU
    input  mipsPkg::word_t    aluResult,
    input  mipsPkg::word_t    memReadData,
    output mipsPkg::word_t    rsData,
    output mipsPkg::word_t    rtData
);
    import mipsPkg::*;

    localparam int NumRegs = 2 ** RegAddrWidth;  // Thirty-two entries

    word_t regs [NumRegs];  // General purpose registers
    word_t writeData;       // Selected write-back value

    assign writeData = memToReg ? memReadData : aluResult;
    assign rsData    = regs[rsAddr];   // Combinational reads
    assign rtData    = regs[rtAddr];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regWriteEn && (regWriteAddr != '0)) begin  // r0 hardwired
            regs[regWriteAddr] <= writeData;
        end
    end

    // r0 reads zero whatever the decoder asks to write
    assertZeroReg: assert property (@(posedge Clk) disable iff (!rstN)
        regs[0] == '0)
        else $error("register zero changed to %h", regs[0]);

endmodule

//--- hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  mipsPkg::word_t                     instr,
    output mipsPkg::regAddr_t                  rsAddr,
    output mipsPkg::regAddr_t                  rtAddr,
    output mipsPkg::regAddr_t                  regWriteAddr,
    output mipsPkg::word_t                     imm,        // Sign-extended
    output logic [mipsPkg::JumpIndexWidth-1:0] jumpIndex,
    output logic                               regWriteEn,
    output logic                               memWriteEn,
    output logic                               memToReg,
    output logic                               aluSrcImm,
    output logic                               branchEq,
    output logic                               branchNe,
    output logic                               jump,
    output mipsPkg::aluOp_e                    aluOp
);
    import mipsPkg::*;

    opcode_e  opcode;   // instr[31:26]
    funct_e   funct;    // instr[5:0], R-type only
    regAddr_t rdAddr;   // R-type destination

    assign opcode    = opcode_e'(instr[31:26]);
    assign funct     = funct_e'(instr[5:0]);
    assign rsAddr    = instr[25:21];
    assign rtAddr    = instr[20:16];
    assign rdAddr    = instr[15:11];
    assign jumpIndex = instr[JumpIndexWidth-1:0];
    assign imm       = {{(WordWidth-ImmWidth){instr[ImmWidth-1]}}, instr[ImmWidth-1:0]};

    always_comb begin
        regWriteEn   = 1'b0;     // Defaults write nothing, store nothing
        memWriteEn   = 1'b0;
        memToReg     = 1'b0;
        aluSrcImm    = 1'b0;
        branchEq     = 1'b0;
        branchNe     = 1'b0;
        jump         = 1'b0;
        aluOp        = aluAdd;
        regWriteAddr = rtAddr;   // I-type destination
        case (opcode)
            opRtype: begin
                regWriteAddr = rdAddr;
                regWriteEn   = 1'b1;
                case (funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: regWriteEn = 1'b0;  // Unknown funct is a no-op
                endcase
            end
            opAddi: begin
                aluSrcImm  = 1'b1;
                regWriteEn = 1'b1;
            end
            opLw: begin
                aluSrcImm  = 1'b1;    // Address is rs plus offset
                memToReg   = 1'b1;
                regWriteEn = 1'b1;
            end
            opSw: begin
                aluSrcImm  = 1'b1;
                memWriteEn = 1'b1;
            end
            opBeq: begin
                branchEq = 1'b1;
                aluOp    = aluSub;    // Zero flag compares rs and rt
            end
            opBne: begin
                branchNe = 1'b1;
                aluOp    = aluSub;
            end
            opJ:     jump = 1'b1;
            default: ;                // Unknown opcode, PC just advances
        endcase
    end

    // A store never writes back, seen by both memory and register file
    always_comb begin
        assert (!(memWriteEn && regWriteEn))
            else $error("decoder drives store and register write together");
    end

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  mipsPkg::word_t  rsData,      // Operand A
    input  mipsPkg::word_t  rtData,
    input  mipsPkg::word_t  imm,         // Already sign-extended
    input  logic            aluSrcImm,   // Pick imm as operand B
    input  mipsPkg::aluOp_e aluOp,
    output mipsPkg::word_t  aluResult,
    output logic            aluZero      // Result is all zero
);
    import mipsPkg::*;

    word_t operandB;   // Second operand after source select
    logic  lessThan;   // Signed A below B

    assign operandB = aluSrcImm ? imm : rtData;
    assign lessThan = $signed(rsData) < $signed(operandB);

    always_comb begin
        case (aluOp)
            aluAnd: begin
                aluResult = rsData & operandB;
            end
            aluOr: begin
                aluResult = rsData | operandB;
            end
            aluAdd: begin
                aluResult = rsData + operandB;    // Also lw/sw address
            end
            aluSub: begin
                aluResult = rsData - operandB;    // Also beq/bne compare
            end
            aluSlt: begin
                aluResult = {{(WordWidth-1){1'b0}}, lessThan};
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

    assign aluZero = (aluResult == '0);

endmodule

//--- hw/mipsPkg.sv
package mipsPkg;

    localparam int WordWidth      = 32;  // Data, address and instruction width
    localparam int RegAddrWidth   = 5;   // Register number width
    localparam int ImmWidth       = 16;  // I-type immediate field
    localparam int JumpIndexWidth = 26;  // J-type target field

    typedef logic [WordWidth-1:0]    word_t;     // Data, addresses, instructions
    typedef logic [RegAddrWidth-1:0] regAddr_t;  // Register number

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        opRtype = 6'd0,   // Register-register, funct selects operation
        opJ     = 6'd2,   // Jump
        opBeq   = 6'd4,   // Branch on equal
        opBne   = 6'd5,   // Branch on not equal
        opAddi  = 6'd8,   // Add immediate
        opLw    = 6'd35,  // Load word
        opSw    = 6'd43   // Store word
    } opcode_e;

    // R-type function code, instr[5:0]
    typedef enum logic [5:0] {
        fnAdd = 6'd32,
        fnSub = 6'd34,
        fnAnd = 6'd36,
        fnOr  = 6'd37,
        fnSlt = 6'd42     // Signed set-on-less-than
    } funct_e;

    // ALU control encoding, bit 2 marks subtraction-based ops
    typedef enum logic [2:0] {
        aluAnd = 3'd0,
        aluOr  = 3'd1,
        aluAdd = 3'd2,
        aluSub = 3'd6,
        aluSlt = 3'd7
    } aluOp_e;

endpackage
